// ==== Bender.yml ====
package:
  name: buscpu

sources:
  - cpuPkg.sv
  - memUnit.sv
  - regFile.sv
  - alu.sv
  - datapath.sv
  - ctrlUnit.sv
  - cpuTop.sv
  - target: test
    files:
      - tbChecker.sv
      - tbCpu.sv

// ==== alu.sv ====
`timescale 1ns/1ps

module alu import cpuPkg::*; (
    input  logic [aluOpWidth-1:0]  aluOp,
    input  logic [dataWidth-1:0]   a,
    input  logic [dataWidth-1:0]   b,
    output logic [2*dataWidth-1:0] result
);

    logic [dataWidth-1:0]          low;
    logic [shamtWidth-1:0]         shamt;
    logic signed [2*dataWidth-1:0] product;

    // Shift amount from the low bits of b
    assign shamt   = b[shamtWidth-1:0];
    assign product = $signed(a) * $signed(b);

    always_comb begin
        case (aluOp)
            aluAdd: begin
                low = a + b;
            end
            aluSub: begin
                low = a - b;
            end
            aluAnd: begin
                low = a & b;
            end
            aluOr: begin
                low = a | b;
            end
            aluShl: begin
                low = a << shamt;
            end
            aluShr: begin
                low = a >> shamt;
            end
            // PC step, the bus carries PC
            aluInc: begin
                low = b + 1'b1;
            end
            default: begin
                low = '0;
            end
        endcase
    end

    // Only the product uses the upper half
    always_comb begin
        if (aluOp == aluMul) begin
            result = product;
        end else begin
            result = {{dataWidth{1'b0}}, low};
        end
    end

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

    // Datapath and memory sizes
    localparam int dataWidth   = 32;
    localparam int ramDepth    = 512;
    localparam int addrWidth   = 9;
    localparam int numRegs     = 16;
    localparam int regIdxWidth = 4;
    localparam int immWidth    = 19;
    localparam int shamtWidth  = 5;

    // ALU operation select
    localparam int aluOpWidth = 3;
    localparam logic [aluOpWidth-1:0] aluAdd = 3'd0;
    localparam logic [aluOpWidth-1:0] aluSub = 3'd1;
    localparam logic [aluOpWidth-1:0] aluAnd = 3'd2;
    localparam logic [aluOpWidth-1:0] aluOr  = 3'd3;
    localparam logic [aluOpWidth-1:0] aluShl = 3'd4;
    localparam logic [aluOpWidth-1:0] aluShr = 3'd5;
    localparam logic [aluOpWidth-1:0] aluMul = 3'd6;
    localparam logic [aluOpWidth-1:0] aluInc = 3'd7;

    // Branch condition field codes
    localparam logic [3:0] condZero    = 4'd0;
    localparam logic [3:0] condNonzero = 4'd1;

    typedef enum logic [4:0] {
        opLd   = 5'd0,  opLdi  = 5'd1,  opSt   = 5'd2,  opAdd  = 5'd3,
        opSub  = 5'd4,  opAnd  = 5'd5,  opOr   = 5'd6,  opShr  = 5'd7,
        opShl  = 5'd8,  opAddi = 5'd9,  opMul  = 5'd10, opMfhi = 5'd11,
        opMflo = 5'd12, opIn   = 5'd13, opOut  = 5'd14, opBrzr = 5'd15,
        opBrnz = 5'd16, opNop  = 5'd17, opHalt = 5'd18
    } opcodeT;

    typedef enum logic [3:0] {
        phIdle   = 4'd0, phFetch0 = 4'd1, phFetch1 = 4'd2, phFetch2 = 4'd3,
        phExec0  = 4'd4, phExec1  = 4'd5, phExec2  = 4'd6, phExec3  = 4'd7,
        phExec4  = 4'd8, phHalt   = 4'd9
    } phaseT;

    // One instruction word, three ways to read it
    typedef union packed {
        struct packed {
            opcodeT      opcode;
            logic [3:0]  ra;
            logic [3:0]  rb;
            logic [3:0]  rc;
            logic [14:0] spare;
        } regV;
        struct packed {
            opcodeT              opcode;
            logic [3:0]          ra;
            logic [3:0]          rb;
            logic [immWidth-1:0] imm;
        } immV;
        struct packed {
            opcodeT              opcode;
            logic [3:0]          ra;
            logic [3:0]          cond;
            logic [immWidth-1:0] imm;
        } brV;
    } instrU;

endpackage

// ==== cpuStim.txt ====
# test <name> | in <port value> | w <start addr> <count> <words> | e <count> <outputs>
# run starts the CPU and waits for halt; addresses, words and values hex, counts decimal
# ldi, add, sub, and, or, addi
test regAlu
in 00000000
w 000 7 08800064 09000007 19890000 71800000 22108000 72000000 2A890000
w 007 6 72800000 33090000 73000000 4B8FFFFF 73800000 90000000
e 5 0000006B FFFFFFA3 00000004 00000067 00000063
run
# shl, shr, then two signed products read back through HI and LO
test shiftMul
in 00000000
w 000 7 08800005 09000003 41890000 71800000 0A07FF00 3AA10000 72800000
w 007 7 0B03FFFF 52300000 5B800000 61800000 73800000 71800000 53300000
w 00E 5 5B800000 61800000 73800000 71800000 90000000
e 6 00000028 1FFFFFE0 FFFFFFFF FC000100 0000000F FFF80001
run
# R0 holds 55 but reads as zero when used as base
test memory
in 00000000
w 000 7 08000055 08800100 09001234 0987FFFE 11080005 118001F0 02080005
w 007 7 028001F0 030800F0 72000000 72800000 73000000 70000000 90000000
e 4 00001234 FFFFFFFE FFFFFFFE 00000055
run
# Countdown with brnz, then a taken and a not-taken brzr
test branches
in 00000000
w 000 6 08800003 70800000 488FFFFF 808FFFFD 78800002 70800000
w 006 5 90000000 09000077 79000001 71000000 90000000
e 4 00000003 00000002 00000001 00000077
run
test inPort
in 12345678
w 000 6 68800000 88000000 49080010 71000000 70800000 90000000
e 2 12345688 12345678
run

// ==== cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 start,
    input  logic                 loadEn,
    input  logic [addrWidth-1:0] loadAddr,
    input  logic [dataWidth-1:0] loadData,
    input  logic [dataWidth-1:0] inPortData,
    output logic [dataWidth-1:0] outPortData,
    output logic                 outStrobe,
    output logic                 running,
    output logic                 halted
);

    // Strobes from the control unit into the datapath
    logic Gra, Grb, Grc, Rin, Rout, BAout;
    logic PCout, PCin, incPC, IRin, Yin, Zin;
    logic ZHighOut, ZLowOut, HIin, HIout, LOin, LOout;
    logic MDRout, Cout, MARin, MDRin, read, write;
    logic InPortIn, InPortOut, OutPortIn, CONN_in;
    logic [aluOpWidth-1:0] aluOp;

    // Back to the control unit
    instrU ir;
    logic  branchFlag;

    ctrlUnit uCtrl (.*);

    datapath uPath (.*);

endmodule

// ==== ctrlUnit.sv ====
`timescale 1ns/1ps

module ctrlUnit import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  start,
    input  instrU                 ir,
    input  logic                  branchFlag,
    output logic                  Gra, Grb, Grc, Rin, Rout, BAout,
    output logic                  PCout, PCin, incPC, IRin, Yin, Zin,
    output logic                  ZHighOut, ZLowOut, HIin, HIout, LOin, LOout,
    output logic                  MDRout, Cout, MARin, MDRin, read, write,
    output logic                  InPortIn, InPortOut, OutPortIn, CONN_in,
    output logic [aluOpWidth-1:0] aluOp,
    output logic                  running,
    output logic                  halted
);

    phaseT  phase, nextPhase, lastPhase;
    opcodeT op;

    assign op      = ir.regV.opcode;
    assign running = (phase != phIdle) && (phase != phHalt);
    assign halted  = (phase == phHalt);

    // Final execute phase for each instruction
    always_comb begin
        case (op)
            opLd:                                      lastPhase = phExec4;
            opSt, opMul:                               lastPhase = phExec3;
            opAdd, opSub, opAnd, opOr, opShl, opShr,
            opAddi, opBrzr, opBrnz:                    lastPhase = phExec2;
            opLdi, opMfhi, opMflo, opIn, opOut:        lastPhase = phExec1;
            default:                                   lastPhase = phExec0;
        endcase
    end

    always_comb begin
        case (phase)
            phIdle, phHalt: nextPhase = start ? phFetch0 : phase;
            phFetch0:       nextPhase = phFetch1;
            phFetch1:       nextPhase = phFetch2;
            phFetch2:       nextPhase = phExec0;
            default: begin
                if (phase != lastPhase) begin
                    nextPhase = phaseT'(phase + 4'd1);
                end else if (op == opHalt) begin
                    nextPhase = phHalt;
                end else begin
                    nextPhase = phFetch0;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= phIdle;
        end else begin
            phase <= nextPhase;
        end
    end

    always_comb begin
        case (op)
            opSub:   aluOp = aluSub;
            opAnd:   aluOp = aluAnd;
            opOr:    aluOp = aluOr;
            opShl:   aluOp = aluShl;
            opShr:   aluOp = aluShr;
            opMul:   aluOp = aluMul;
            default: aluOp = aluAdd;
        endcase
    end

    always_comb begin
        {Gra, Grb, Grc, Rin, Rout, BAout, PCout, PCin, incPC, IRin} = '0;
        {Yin, Zin, ZHighOut, ZLowOut, HIin, HIout, LOin, LOout, MDRout} = '0;
        {Cout, MARin, MDRin, read, write, InPortIn, InPortOut, OutPortIn, CONN_in} = '0;
        case (phase)
            // Empty bus on start clears PC
            phIdle, phHalt: PCin = start;
            phFetch0: begin
                PCout = 1'b1;
                MARin = 1'b1;
                incPC = 1'b1;
                Zin   = 1'b1;
            end
            // Y keeps PC+1 as the branch base
            phFetch1: begin
                ZLowOut = 1'b1;
                PCin    = 1'b1;
                Yin     = 1'b1;
                read    = 1'b1;
            end
            phFetch2: begin
                MDRout = 1'b1;
                IRin   = 1'b1;
            end
            phExec0: begin
                case (op)
                    opAdd, opSub, opAnd, opOr, opShl, opShr, opAddi: begin
                        Grb  = 1'b1;
                        Rout = 1'b1;
                        Yin  = 1'b1;
                    end
                    opMul: begin
                        Gra  = 1'b1;
                        Rout = 1'b1;
                        Yin  = 1'b1;
                    end
                    opLd, opSt: begin
                        Grb   = 1'b1;
                        BAout = 1'b1;
                        Yin   = 1'b1;
                    end
                    opLdi, opMfhi, opMflo: begin
                        Cout  = (op == opLdi);
                        HIout = (op == opMfhi);
                        LOout = (op == opMflo);
                        Gra   = 1'b1;
                        Rin   = 1'b1;
                    end
                    opIn: InPortIn = 1'b1;
                    opOut, opBrzr, opBrnz: begin
                        Gra       = 1'b1;
                        Rout      = 1'b1;
                        OutPortIn = (op == opOut);
                        CONN_in   = (op != opOut);
                    end
                    default: ;
                endcase
            end
            phExec1: begin
                case (op)
                    opAdd, opSub, opAnd, opOr, opShl, opShr, opMul: begin
                        Grc  = (op != opMul);
                        Grb  = (op == opMul);
                        Rout = 1'b1;
                        Zin  = 1'b1;
                    end
                    opAddi, opLd, opSt, opBrzr, opBrnz: begin
                        Cout = 1'b1;
                        Zin  = 1'b1;
                    end
                    opIn: begin
                        InPortOut = 1'b1;
                        Gra       = 1'b1;
                        Rin       = 1'b1;
                    end
                    default: ;
                endcase
            end
            // Every instruction that gets this far reads Z low here
            phExec2: begin
                ZLowOut = 1'b1;
                case (op)
                    opMul:         LOin  = 1'b1;
                    opLd, opSt:    MARin = 1'b1;
                    opBrzr, opBrnz: PCin = branchFlag;
                    default: begin
                        Gra = 1'b1;
                        Rin = 1'b1;
                    end
                endcase
            end
            phExec3: begin
                ZHighOut = (op == opMul);
                HIin     = (op == opMul);
                read     = (op == opLd);
                Gra      = (op == opSt);
                Rout     = (op == opSt);
                MDRin    = (op == opSt);
                write    = (op == opSt);
            end
            phExec4: begin
                MDRout = 1'b1;
                Gra    = 1'b1;
                Rin    = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== datapath.sv ====
`timescale 1ns/1ps

module datapath import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  Gra, Grb, Grc, Rin, Rout, BAout,
    input  logic                  PCout, PCin, incPC, IRin, Yin, Zin,
    input  logic                  ZHighOut, ZLowOut, HIin, HIout, LOin, LOout,
    input  logic                  MDRout, Cout, MARin, MDRin, read, write,
    input  logic                  InPortIn, InPortOut, OutPortIn, CONN_in,
    input  logic [aluOpWidth-1:0] aluOp,
    input  logic                  running,
    input  logic                  loadEn,
    input  logic [addrWidth-1:0]  loadAddr,
    input  logic [dataWidth-1:0]  loadData,
    input  logic [dataWidth-1:0]  inPortData,
    output instrU                 ir,
    output logic                  branchFlag,
    output logic [dataWidth-1:0]  outPortData,
    output logic                  outStrobe
);

    logic [dataWidth-1:0]   bus;
    logic [dataWidth-1:0]   pc, yReg, hiReg, loReg, inPortReg;
    logic [2*dataWidth-1:0] zReg;
    logic [2*dataWidth-1:0] aluResult;
    logic [dataWidth-1:0]   regOut, cSignExt, mdrOut;
    logic [aluOpWidth-1:0]  aluSel;
    logic                   condMet;

    // RAM is only open to the boot loader while stopped
    memUnit uMem (
        .clk(clk), .rstN(rstN), .MARin(MARin), .MDRin(MDRin),
        .read(read), .write(write), .busIn(bus),
        .loadEn(loadEn && !running), .loadAddr(loadAddr), .loadData(loadData),
        .mdrOut(mdrOut)
    );

    regFile uRegs (
        .clk(clk), .rstN(rstN), .ir(ir), .Gra(Gra), .Grb(Grb), .Grc(Grc),
        .Rin(Rin), .Rout(Rout), .BAout(BAout), .busIn(bus),
        .regOut(regOut), .cSignExt(cSignExt)
    );

    assign aluSel = incPC ? aluInc : aluOp;

    alu uAlu (.aluOp(aluSel), .a(yReg), .b(bus), .result(aluResult));

    // Bus mux, zero when nothing drives it
    always_comb begin
        case (1'b1)
            Rout, BAout: bus = regOut;
            PCout:       bus = pc;
            ZHighOut:    bus = zReg[2*dataWidth-1:dataWidth];
            ZLowOut:     bus = zReg[dataWidth-1:0];
            HIout:       bus = hiReg;
            LOout:       bus = loReg;
            MDRout:      bus = mdrOut;
            InPortOut:   bus = inPortReg;
            Cout:        bus = cSignExt;
            default:     bus = '0;
        endcase
    end

    always_comb begin
        case (ir.brV.cond)
            condZero:    condMet = (bus == '0);
            condNonzero: condMet = (bus != '0);
            default:     condMet = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc          <= '0;
            ir          <= '0;
            yReg        <= '0;
            zReg        <= '0;
            hiReg       <= '0;
            loReg       <= '0;
            inPortReg   <= '0;
            outPortData <= '0;
            outStrobe   <= 1'b0;
            branchFlag  <= 1'b0;
        end else begin
            if (PCin) pc <= bus;
            if (IRin) ir <= bus;
            if (Yin) yReg <= bus;
            if (Zin) zReg <= aluResult;
            if (HIin) hiReg <= bus;
            if (LOin) loReg <= bus;
            if (InPortIn) inPortReg <= inPortData;
            if (OutPortIn) outPortData <= bus;
            if (CONN_in) branchFlag <= condMet;
            // Strobe trails the port load by one cycle
            outStrobe <= OutPortIn;
        end
    end

endmodule

// ==== memUnit.sv ====
`timescale 1ns/1ps

module memUnit import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 MARin,
    input  logic                 MDRin,
    input  logic                 read,
    input  logic                 write,
    input  logic [dataWidth-1:0] busIn,
    input  logic                 loadEn,
    input  logic [addrWidth-1:0] loadAddr,
    input  logic [dataWidth-1:0] loadData,
    output logic [dataWidth-1:0] mdrOut
);

    logic [dataWidth-1:0] ram [ramDepth];
    logic [addrWidth-1:0] mar;
    logic [dataWidth-1:0] mdr;
    logic [dataWidth-1:0] mdrNext;

    // MDR source, RAM word at MAR on read, else the bus
    assign mdrNext = read ? ram[mar] : busIn;
    assign mdrOut  = mdr;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (MARin) begin
                mar <= busIn[addrWidth-1:0];
            end
            if (MDRin || read) begin
                mdr <= mdrNext;
            end
        end
    end

    // Store takes the value MDR takes at this edge
    // Boot load only gets the port when no store is under way
    always_ff @(posedge clk) begin
        if (write) begin
            ram[mar] <= mdrNext;
        end else if (loadEn) begin
            ram[loadAddr] <= loadData;
        end
    end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  instrU                ir,
    input  logic                 Gra,
    input  logic                 Grb,
    input  logic                 Grc,
    input  logic                 Rin,
    input  logic                 Rout,
    input  logic                 BAout,
    input  logic [dataWidth-1:0] busIn,
    output logic [dataWidth-1:0] regOut,
    output logic [dataWidth-1:0] cSignExt
);

    logic [regIdxWidth-1:0] sel;
    logic [numRegs-1:0]     oneHot;
    logic [numRegs-1:0]     writeEn;
    logic [numRegs-1:0]     readEn;
    logic [dataWidth-1:0]   regs [numRegs];

    // Register field named by the group strobe
    always_comb begin
        if (Gra) begin
            sel = ir.regV.ra;
        end else if (Grb) begin
            sel = ir.regV.rb;
        end else if (Grc) begin
            sel = ir.regV.rc;
        end else begin
            sel = '0;
        end
    end

    assign oneHot  = {{(numRegs-1){1'b0}}, 1'b1} << sel;
    assign writeEn = Rin ? oneHot : '0;
    assign readEn  = (Rout || BAout) ? oneHot : '0;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < numRegs; i++) begin
                if (writeEn[i]) begin
                    regs[i] <= busIn;
                end
            end
        end
    end

    always_comb begin
        regOut = '0;
        for (int i = 0; i < numRegs; i++) begin
            // R0 as a base address reads as zero
            if (readEn[i] && !(BAout && i == 0)) begin
                regOut = regOut | regs[i];
            end
        end
    end

    assign cSignExt = {{(dataWidth-immWidth){ir.immV.imm[immWidth-1]}}, ir.immV.imm};

endmodule

// ==== src.f ====
cpuPkg.sv
memUnit.sv
regFile.sv
alu.sv
datapath.sv
ctrlUnit.sv
cpuTop.sv
tbChecker.sv
tbCpu.sv

// ==== tbChecker.sv ====
`timescale 1ns/1ps

module tbChecker import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 outStrobe,
    input  logic [dataWidth-1:0] outPortData,
    input  logic                 running,
    input  logic                 halted,
    output int                   failCount
);

    string                testName;
    logic [dataWidth-1:0] expQ [$];
    logic [dataWidth-1:0] expVal;
    logic [dataWidth-1:0] lastOut;
    bit                   active;
    bit                   testBad;
    int                   passCount;

    initial begin
        failCount = 0;
        passCount = 0;
        active    = 1'b0;
        testBad   = 1'b0;
        lastOut   = '0;
    end

    task automatic compareWord(input string label, input logic [dataWidth-1:0] expected,
                               input logic [dataWidth-1:0] actual);
        if (actual !== expected) begin
            $display("error %s expected %h actual %h", label, expected, actual);
            testBad = 1'b1;
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        expQ.delete();
        testBad = 1'b0;
        active  = 1'b1;
    endtask

    task automatic expectValue(input logic [dataWidth-1:0] value);
        expQ.push_back(value);
    endtask

    // Verdict line once the CPU has halted or given up
    task automatic finishTest(input bit timedOut);
        active = 1'b0;
        if (timedOut) begin
            $display("%s: CPU did not reach halt within the cycle limit", testName);
            testBad = 1'b1;
        end
        if (expQ.size() != 0) begin
            $display("%s: too few outputs, %0d expected values never came",
                     testName, expQ.size());
            testBad = 1'b1;
        end
        if (testBad) begin
            failCount++;
            $display("%s: FAILED", testName);
        end else begin
            passCount++;
            $display("%s: ok", testName);
        end
    endtask

    // Everything quiet after reset, before any start
    task automatic checkIdle();
        startTest("reset");
        compareWord("reset running", '0, {{(dataWidth-1){1'b0}}, running});
        compareWord("reset halted", '0, {{(dataWidth-1){1'b0}}, halted});
        compareWord("reset outStrobe", '0, {{(dataWidth-1){1'b0}}, outStrobe});
        compareWord("reset outPortData", '0, outPortData);
        finishTest(1'b0);
    endtask

    task automatic summary();
        $display("tests: %0d passed, %0d failed", passCount, failCount);
    endtask

    // Port data is settled half a cycle after the strobe rises
    always @(negedge clk) begin
        if (outStrobe) begin
            lastOut = outPortData;
            if (!active) begin
                $display("output %h appeared while no test was running", outPortData);
                failCount++;
            end else if (expQ.size() == 0) begin
                $display("%s: too many outputs, extra value %h", testName, outPortData);
                testBad = 1'b1;
            end else begin
                expVal = expQ.pop_front();
                compareWord(testName, expVal, outPortData);
            end
        end else if (outPortData !== lastOut) begin
            // Port must hold its value between out instructions
            $display("%s: output port changed to %h without an out strobe",
                     testName, outPortData);
            if (active) begin
                testBad = 1'b1;
            end else begin
                failCount++;
            end
            lastOut = outPortData;
        end
    end

endmodule

// ==== tbCpu.sv ====
`timescale 1ns/1ps

module tbCpu import cpuPkg::*;;

    localparam int haltLimit  = 2000;
    localparam int startLimit = 10;

    logic                 clk;
    logic                 rstN;
    logic                 start;
    logic                 loadEn;
    logic [addrWidth-1:0] loadAddr;
    logic [dataWidth-1:0] loadData;
    logic [dataWidth-1:0] inPortData;
    logic [dataWidth-1:0] outPortData;
    logic                 outStrobe;
    logic                 running;
    logic                 halted;
    int                   failCount;

    cpuTop u_dut (.*);

    tbChecker uCheck (
        .clk(clk), .outStrobe(outStrobe), .outPortData(outPortData),
        .running(running), .halted(halted), .failCount(failCount)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Inputs change 1 ns after the rising edge
    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    // Word lands in RAM at the following edge
    task automatic writeWord(input logic [addrWidth-1:0] addr,
                             input logic [dataWidth-1:0] data);
        stepCycle();
        loadEn   = 1'b1;
        loadAddr = addr;
        loadData = data;
    endtask

    task automatic runProgram(input logic [dataWidth-1:0] inValue, output bit timedOut);
        int cycles;
        stepCycle();
        loadEn     = 1'b0;
        inPortData = inValue;
        start      = 1'b1;
        stepCycle();
        start  = 1'b0;
        cycles = 0;
        while (!running && cycles < startLimit) begin
            stepCycle();
            cycles++;
        end
        cycles = 0;
        while (running && !halted && cycles < haltLimit) begin
            stepCycle();
            cycles++;
        end
        timedOut = !halted;
    endtask

    initial begin
        string                tok;
        string                name;
        logic [8*100-1:0]     rest;
        logic [dataWidth-1:0] addr;
        logic [dataWidth-1:0] word;
        logic [dataWidth-1:0] inValue;
        int                   fd;
        int                   n;
        int                   count;
        bit                   timedOut;
        bit                   aborted;
        rstN       = 1'b0;
        start      = 1'b0;
        loadEn     = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        inPortData = '0;
        inValue    = '0;
        aborted    = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;
        stepCycle();
        uCheck.checkIdle();
        fd = $fopen("cpuStim.txt", "r");
        if (fd == 0) begin
            $display("could not open cpuStim.txt");
            aborted = 1'b1;
        end
        while (!aborted && $fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                n = $fgets(rest, fd);
            end else if (tok == "test") begin
                n = $fscanf(fd, "%s", name);
                uCheck.startTest(name);
            end else if (tok == "in") begin
                n = $fscanf(fd, "%h", inValue);
            end else if (tok == "w") begin
                n = $fscanf(fd, "%h %d", addr, count);
                for (int i = 0; i < count; i++) begin
                    n = $fscanf(fd, "%h", word);
                    writeWord(addr[addrWidth-1:0] + i, word);
                end
            end else if (tok == "e") begin
                n = $fscanf(fd, "%d", count);
                for (int i = 0; i < count; i++) begin
                    n = $fscanf(fd, "%h", word);
                    uCheck.expectValue(word);
                end
            end else if (tok == "run") begin
                runProgram(inValue, timedOut);
                uCheck.finishTest(timedOut);
                // A CPU that never halts cannot take the next program
                aborted = timedOut;
            end else begin
                $display("unknown keyword %s in cpuStim.txt", tok);
                aborted = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        uCheck.summary();
        if (failCount == 0 && !aborted) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
